// ==== testbench/decodePatterns.txt ====
# D addr mask ovl rnW tt tm selects bank accessType; selects MSB first: romEnN ramSpaceN regSpaceN ciaCs0N ciaCs1N rtcSpace autovector ataSpace ataEnN priCs0 priCs1 secCs0 secCs1 bridgeRegEnN proEnN flashSpace
# W addr data bridgeBase ataBase proBase configured; C addr setup hold ciaCs0N ciaCs1N restart; R reset
D 00000000 00060000 1 1 0 0 0111100010000110 0 2
D 00000000 00060000 0 1 0 0 1011100010000110 0 2
D 00F80000 00060000 1 1 0 0 0111100010000110 3 2
D 00F80000 00060000 0 1 0 0 0111100010000110 3 2
D 00BF0000 00000000 0 1 0 0 1111100010000110 1 2
D 00DF0000 00000000 0 1 0 0 1101100010000110 3 2
D 00DC0000 00000000 0 1 0 0 1111110010000110 3 2
D 00E80000 00000000 0 1 0 0 1111100010000110 2 2
D 00A80000 00000000 0 1 0 0 1111100010000111 0 2
D 00B00000 00000000 0 1 0 0 1111100010000111 1 2
D 00E00000 00000000 0 1 0 0 1111100010000111 2 2
D 00F00000 00000000 0 1 0 0 1111100010000111 3 2
D 01DF0000 00000000 0 1 0 0 1111100010000110 3 2
D 01DC0000 00000000 0 1 0 0 1111100010000110 3 2
D 10A80000 00000000 0 1 0 0 1111100010000110 0 2
D FFFF0000 00000000 0 1 3 0 1111101010000110 3 2
D 00600000 00000000 0 1 0 0 1111100010000110 2 2
D 00440000 00000000 0 0 0 0 1111100010000110 2 2
D 40000000 00000000 0 1 0 0 1111100010000110 0 2
C 00BF0000 3 4 0 0 0
C 00BF1000 3 4 1 0 1
C 00BF2000 3 4 0 1 0
W 00E82000 60 60 00 00 0
W 00E83000 00 60 00 00 0
W 00E81000 40 60 00 04 1
D 00440000 00000000 0 1 0 0 1111100010000110 2 2
R
W 00E82000 60 60 00 00 0
W 00E82000 44 60 22 00 0
W 00E81000 40 60 22 04 1
W 00E82000 11 60 22 04 1
D 00600000 00000000 0 1 0 0 1111100010000010 2 2
D 00610000 00000000 0 1 0 0 1111100010000110 2 2
D 00440000 00000000 0 1 0 0 1111100110000110 2 2
D 00441000 00000000 0 1 0 0 1111100111000110 2 2
D 00445000 00000000 0 1 0 0 1111100110100110 2 2
D 00442000 00000000 0 1 0 0 1111100110010110 2 2
D 00446000 00000000 0 1 0 0 1111100110001110 2 2
D 00460000 00000000 0 1 0 0 1111100010000110 2 2
D 00441000 00000000 0 0 0 0 1111100101000110 2 2
D 00440000 00000000 0 1 0 0 1111100100000110 2 2
D 00460000 00000000 0 1 0 0 1111100010000110 2 2
D 40000000 00000000 0 1 0 0 1111100010000100 0 2
D 50000000 00000000 0 1 0 0 1111100010000110 0 2
D 4FC00000 00000000 0 1 0 0 1111100010000100 2 0
D 4FD00000 00000000 0 1 0 0 1111100010000100 3 1
D 4FE00000 00000000 0 1 0 0 1111100010000100 2 3
D 00000000 00000000 0 1 2 0 1011100010000110 0 0
D 00000000 00000000 0 1 2 3 1011100010000110 0 1
D 00000000 00000000 0 1 0 0 1011100010000110 0 2

// ==== amigaPciDecode.f ====
design/addrMapPkg.sv
design/busCyclePkg.sv
design/addressDecode.sv
design/autoconfigChain.sv
design/ciaCycle.sv
design/amigaPciDecode.sv
testbench/amigaPciDecode_asserts.sv
testbench/amigaPciDecodeTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module amigaPciDecodeTb \
  -f amigaPciDecode.f \
  -o amigaPciDecodeSim

# A failing run still leaves its log for the search below
./obj_dir/amigaPciDecodeSim > sim.log 2>&1 || true

if grep -q "SIMULATION PASSED" sim.log; then
  echo "Run passed"
  exit 0
else
  echo "Run failed, see sim.log"
  exit 1
fi

// ==== testbench/amigaPciDecodeTb.sv ====
// Amiga PCI decode testbench
module amigaPciDecodeTb;
  import addrMapPkg::*;
  import busCyclePkg::*;

  // Cycle limit for every wait loop
  localparam int waitLimit = 64;

  logic                CLK40;
  logic                RESETn;
  logic [31:12]        addr;
  logic                rnW;
  transferType         tt;
  transferMod          tm;
  logic                transferStart;
  logic                ovl;
  logic [7:0]          data;
  logic                writeStrobe;
  logic                romEnN;
  logic                ramSpaceN;
  logic                regSpaceN;
  logic                ciaCs0N;
  logic                ciaCs1N;
  logic                rtcSpace;
  logic                autovector;
  logic                ataSpace;
  logic                ataEnN;
  logic                priCs0;
  logic                priCs1;
  logic                secCs0;
  logic                secCs1;
  logic                bridgeRegEnN;
  logic                proEnN;
  pciAccessType        accessType;
  logic                flashSpace;
  logic [1:0]          flashBank;
  logic                configured;
  logic                ciaAck;

  // Select vector names, MSB first as in the pattern file
  string selNames [16] = '{"romEnN", "ramSpaceN", "regSpaceN", "ciaCs0N", "ciaCs1N",
                           "rtcSpace", "autovector", "ataSpace", "ataEnN", "priCs0",
                           "priCs1", "secCs0", "secCs1", "bridgeRegEnN", "proEnN",
                           "flashSpace"};

  amigaPciDecode #(
    .ciaSetupCycles (3),
    .ciaHoldCycles  (4)
  ) dut_i (
    .CLK40 (CLK40), .RESETn (RESETn), .addr (addr), .rnW (rnW), .tt (tt), .tm (tm),
    .transferStart (transferStart), .ovl (ovl), .data (data), .writeStrobe (writeStrobe),
    .romEnN (romEnN), .ramSpaceN (ramSpaceN), .regSpaceN (regSpaceN),
    .ciaCs0N (ciaCs0N), .ciaCs1N (ciaCs1N), .rtcSpace (rtcSpace),
    .autovector (autovector), .ataSpace (ataSpace), .ataEnN (ataEnN),
    .priCs0 (priCs0), .priCs1 (priCs1), .secCs0 (secCs0), .secCs1 (secCs1),
    .bridgeRegEnN (bridgeRegEnN), .proEnN (proEnN), .accessType (accessType),
    .flashSpace (flashSpace), .flashBank (flashBank), .configured (configured),
    .ciaAck (ciaAck)
  );

  initial begin
    CLK40 = 1'b0;
    forever #5 CLK40 = ~CLK40;
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic failRun;
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic checkSelect(string name, logic actual, logic expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
      failRun();
    end
  endtask

  task automatic checkAccessType(string name, pciAccessType actual, pciAccessType expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected %s, got %s", $time, name, expected.name(),
               actual.name());
      failRun();
    end
  endtask

  task automatic checkBank(string name, logic [1:0] actual, logic [1:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      failRun();
    end
  endtask

  task automatic checkBase(string name, logic [bridgeBaseWidth-1:0] actual,
                           logic [bridgeBaseWidth-1:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      failRun();
    end
  endtask

  //////////////////////////////////////////////////
  // Pattern runners
  //////////////////////////////////////////////////

  // Reset held over 8 falling edges
  task automatic applyReset;
    @(negedge CLK40);
    RESETn        = 1'b0;
    transferStart = 1'b0;
    writeStrobe   = 1'b0;
    repeat (8) @(negedge CLK40);
    RESETn = 1'b1;
  endtask

  task automatic waitConfigured;
    int n;
    n = 0;
    while (!configured) begin
      if (n >= waitLimit) begin
        $display("Timeout while waiting for the autoconfig chain to finish");
        failRun();
      end
      @(posedge CLK40);
      #1;
      n++;
    end
  endtask

  // One autoconfig write, bases checked after the edge
  task automatic runWrite(logic [31:0] a, logic [7:0] d, logic [7:0] bridgeExp,
                          logic [7:0] ataExp, logic [7:0] proExp, logic confExp);
    @(negedge CLK40);
    addr          = a[31:12];
    data          = d;
    rnW           = 1'b0;
    tt            = normal;
    tm            = 3'b000;
    transferStart = 1'b0;
    writeStrobe   = 1'b1;
    @(posedge CLK40);
    #1;
    checkBase("bridgeBase", dut_i.bridgeBase, bridgeExp);
    checkBase("ataBase", 8'(dut_i.ataBase), ataExp);
    checkBase("proBase", 8'(dut_i.proBase), proExp);
    if (confExp) begin
      waitConfigured();
    end
    checkSelect("configured", configured, confExp);
    // Strobe is a single cycle
    @(negedge CLK40);
    writeStrobe = 1'b0;
    rnW         = 1'b1;
  endtask

  task automatic runDecode(logic [31:0] a, logic [31:0] mask, logic ovlV, logic rnWV,
                           logic [1:0] ttV, logic [2:0] tmV, logic [15:0] expSel,
                           logic [1:0] expBank, logic [1:0] expAcc);
    logic [31:0] filled;
    logic [15:0] actual;
    // Don't care bits from the seeded generator
    filled = (a & ~mask) | ($urandom() & mask);
    @(negedge CLK40);
    addr          = filled[31:12];
    ovl           = ovlV;
    rnW           = rnWV;
    tt            = transferType'(ttV);
    tm            = tmV;
    transferStart = 1'b0;
    writeStrobe   = 1'b0;
    @(posedge CLK40);
    #1;
    actual = {romEnN, ramSpaceN, regSpaceN, ciaCs0N, ciaCs1N, rtcSpace, autovector,
              ataSpace, ataEnN, priCs0, priCs1, secCs0, secCs1, bridgeRegEnN, proEnN,
              flashSpace};
    for (int j = 0; j < 16; j++) begin
      checkSelect(selNames[j], actual[15-j], expSel[15-j]);
    end
    checkBank("flashBank", flashBank, expBank);
    checkAccessType("accessType", accessType, pciAccessType'(expAcc));
  endtask

  // k counts rising edges after the one that took the pulse
  task automatic runCia(logic [31:0] a, int setupV, int holdV, logic cs0Exp,
                        logic cs1Exp, logic restart);
    int   k;
    logic inWin;
    logic ackSeen;
    @(negedge CLK40);
    addr          = a[31:12];
    rnW           = 1'b1;
    tt            = normal;
    tm            = 3'b000;
    writeStrobe   = 1'b0;
    transferStart = 1'b1;
    @(posedge CLK40);
    #1;
    k       = 0;
    ackSeen = 1'b0;
    while (!ackSeen) begin
      if (k >= waitLimit) begin
        $display("Timeout while waiting for the CIA acknowledge");
        failRun();
      end
      @(negedge CLK40);
      // Optional second pulse inside the window
      transferStart = restart && (k == setupV + 1);
      @(posedge CLK40);
      #1;
      k++;
      inWin = (k >= setupV) && (k < setupV + holdV);
      checkSelect("ciaCs0N", ciaCs0N, inWin ? cs0Exp : 1'b1);
      checkSelect("ciaCs1N", ciaCs1N, inWin ? cs1Exp : 1'b1);
      checkSelect("ciaAck", ciaAck, inWin && (k == setupV + holdV - 1));
      ackSeen = ciaAck;
    end
    // Window must not reopen
    repeat (setupV + 2) begin
      @(negedge CLK40);
      transferStart = 1'b0;
      @(posedge CLK40);
      #1;
      checkSelect("ciaCs0N", ciaCs0N, 1'b1);
      checkSelect("ciaCs1N", ciaCs1N, 1'b1);
      checkSelect("ciaAck", ciaAck, 1'b0);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int          fd;
    int          code;
    int          patternCount;
    int          iA;
    int          iB;
    int          iC;
    int          iD;
    int          iE;
    int          iF;
    int          iG;
    logic [31:0] hA;
    logic [31:0] hB;
    logic [31:0] hC;
    logic [31:0] hD;
    logic [15:0] selV;
    string       line;
    byte         kind;
    RESETn        = 1'b0;
    addr          = '0;
    rnW           = 1'b1;
    tt            = normal;
    tm            = 3'b000;
    transferStart = 1'b0;
    ovl           = 1'b1;
    data          = 8'h00;
    writeStrobe   = 1'b0;
    patternCount  = 0;
    void'($urandom(32'h9dc5549a));
    applyReset();
    fd = $fopen("testbench/decodePatterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the pattern file");
      failRun();
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
        kind = line.getc(0);
        patternCount++;
        if (kind == "D") begin
          code = $sscanf(line, "D %h %h %d %d %d %d %b %d %d",
                         hA, hB, iA, iB, iC, iD, selV, iE, iF);
          if (code != 9) begin
            $display("Malformed decode pattern: %s", line);
            failRun();
          end
          runDecode(hA, hB, iA[0], iB[0], iC[1:0], iD[2:0], selV, iE[1:0], iF[1:0]);
        end else if (kind == "W") begin
          code = $sscanf(line, "W %h %h %h %h %h %d", hA, hB, hC, hD, selV, iA);
          if (code != 6) begin
            $display("Malformed write pattern: %s", line);
            failRun();
          end
          runWrite(hA, hB[7:0], hC[7:0], hD[7:0], selV[7:0], iA[0]);
        end else if (kind == "C") begin
          code = $sscanf(line, "C %h %d %d %d %d %d", hA, iA, iB, iC, iD, iG);
          if (code != 6) begin
            $display("Malformed CIA pattern: %s", line);
            failRun();
          end
          runCia(hA, iA, iB, iC[0], iD[0], iG[0]);
        end else if (kind == "R") begin
          applyReset();
          checkSelect("configured", configured, 1'b0);
        end else begin
          $display("Unknown pattern kind in line: %s", line);
          failRun();
        end
      end
    end
    $fclose(fd);
    if (patternCount == 0) begin
      $display("Pattern file holds no patterns");
      failRun();
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// ==== testbench/amigaPciDecode_asserts.sv ====
// Decoder protocol assertions
module amigaPciDecodeAsserts (
  input logic CLK40,
  input logic RESETn,
  input logic ciaEnable,
  input logic ciaAck,
  input logic configured,
  input logic priCs0,
  input logic priCs1,
  input logic secCs0,
  input logic secCs1,
  input logic ataSpace,
  input logic ataEnN
);

  // Ack marks the last cycle of the enable window
  ackInWindow: assert property (@(posedge CLK40) disable iff (!RESETn)
    ciaEnable |=> (ciaEnable == !$past(ciaAck)))
    else $error("ciaAck not in the last cycle of the CIA enable window");

  // Chain done is sticky until reset
  configuredSticky: assert property (@(posedge CLK40) disable iff (!RESETn)
    configured |=> configured)
    else $error("configured fell without reset");

  // ATA port selects are exclusive
  ataOneHot: assert property (@(posedge CLK40) disable iff (!RESETn)
    $onehot0({priCs0, priCs1, secCs0, secCs1}))
    else $error("more than one ATA port select active");

  // Port enable stays on for ATA accesses once set
  // and never leaks outside the ATA board
  ataEnInSpace: assert property (@(posedge CLK40) disable iff (!RESETn)
    !ataEnN |=> (ataEnN == !ataSpace))
    else $error("ataEnN does not follow ATA space after the first ATA write");

endmodule

bind amigaPciDecode amigaPciDecodeAsserts amigaPciDecodeAsserts_i (
  .CLK40      (CLK40),
  .RESETn     (RESETn),
  .ciaEnable  (ciaEnable),
  .ciaAck     (ciaAck),
  .configured (configured),
  .priCs0     (priCs0),
  .priCs1     (priCs1),
  .secCs0     (secCs0),
  .secCs1     (secCs1),
  .ataSpace   (ataSpace),
  .ataEnN     (ataEnN)
);

// ==== design/amigaPciDecode.sv ====
// Amiga PCI bridge address decode
module amigaPciDecode #(
  parameter int ciaSetupCycles = 3,
  parameter int ciaHoldCycles  = 4
) (
  input  logic                      CLK40,
  input  logic                      RESETn,
  input  logic [31:12]              addr,
  input  logic                      rnW,
  input  busCyclePkg::transferType  tt,
  input  busCyclePkg::transferMod   tm,
  input  logic                      transferStart,
  input  logic                      ovl,
  input  logic [7:0]                data,
  input  logic                      writeStrobe,
  output logic                      romEnN,
  output logic                      ramSpaceN,
  output logic                      regSpaceN,
  output logic                      ciaCs0N,
  output logic                      ciaCs1N,
  output logic                      rtcSpace,
  output logic                      autovector,
  output logic                      ataSpace,
  output logic                      ataEnN,
  output logic                      priCs0,
  output logic                      priCs1,
  output logic                      secCs0,
  output logic                      secCs1,
  output logic                      bridgeRegEnN,
  output logic                      proEnN,
  output busCyclePkg::pciAccessType accessType,
  output logic                      flashSpace,
  output logic [1:0]                flashBank,
  output logic                      configured,
  output logic                      ciaAck
);
  import addrMapPkg::*;

  logic                       ciaSpace;
  logic                       autoconfigSpace;
  logic                       ciaEnable;
  logic [bridgeBaseWidth-1:0] bridgeBase;
  logic [ataBaseWidth-1:0]    ataBase;
  logic [proBaseWidth-1:0]    proBase;
  logic [7:0]                 acOffset;

  // Bus is 4k grained, so the autoconfig register index rides on A15..A12
  // Index 1, 2, 3 rebuilds offsets 44, 48, 4C
  assign acOffset = {2'b01, addr[15:12], 2'b00};

  addressDecode addressDecode_i (
    .CLK40           (CLK40),
    .RESETn          (RESETn),
    .addr            (addr),
    .rnW             (rnW),
    .tt              (tt),
    .tm              (tm),
    .ovl             (ovl),
    .ciaEnable       (ciaEnable),
    .configured      (configured),
    .bridgeBase      (bridgeBase),
    .ataBase         (ataBase),
    .proBase         (proBase),
    .romEnN          (romEnN),
    .ramSpaceN       (ramSpaceN),
    .regSpaceN       (regSpaceN),
    .ciaSpace        (ciaSpace),
    .ciaCs0N         (ciaCs0N),
    .ciaCs1N         (ciaCs1N),
    .rtcSpace        (rtcSpace),
    .autoconfigSpace (autoconfigSpace),
    .autovector      (autovector),
    .ataSpace        (ataSpace),
    .ataEnN          (ataEnN),
    .priCs0          (priCs0),
    .priCs1          (priCs1),
    .secCs0          (secCs0),
    .secCs1          (secCs1),
    .bridgeRegEnN    (bridgeRegEnN),
    .proEnN          (proEnN),
    .accessType      (accessType),
    .flashSpace      (flashSpace),
    .flashBank       (flashBank)
  );

  autoconfigChain autoconfigChain_i (
    .CLK40           (CLK40),
    .RESETn          (RESETn),
    .autoconfigSpace (autoconfigSpace),
    .offset          (acOffset),
    .data            (data),
    .writeStrobe     (writeStrobe),
    .bridgeBase      (bridgeBase),
    .ataBase         (ataBase),
    .proBase         (proBase),
    .configured      (configured)
  );

  ciaCycle #(
    .ciaSetupCycles (ciaSetupCycles),
    .ciaHoldCycles  (ciaHoldCycles)
  ) ciaCycle_i (
    .CLK40         (CLK40),
    .RESETn        (RESETn),
    .ciaSpace      (ciaSpace),
    .transferStart (transferStart),
    .ciaEnable     (ciaEnable),
    .ciaAck        (ciaAck)
  );

endmodule

// ==== design/ciaCycle.sv ====
// CIA cycle timer
module ciaCycle #(
  parameter int ciaSetupCycles = 3,
  parameter int ciaHoldCycles  = 4
) (
  input  logic CLK40,
  input  logic RESETn,
  input  logic ciaSpace,
  input  logic transferStart,
  output logic ciaEnable,
  output logic ciaAck
);

  // Counter holds at most the larger phase length minus one
  localparam int cntMax   = (ciaSetupCycles > ciaHoldCycles) ? ciaSetupCycles : ciaHoldCycles;
  localparam int cntWidth = (cntMax > 1) ? $clog2(cntMax) : 1;

  typedef enum logic [1:0] {
    phaseIdle,
    phaseSetup,
    phaseHold
  } ciaPhase;

  ciaPhase             phase;
  logic [cntWidth-1:0] count;

  //////////////////////////////////////////////////
  // Phase sequencer
  //////////////////////////////////////////////////

  // Fixed counts stand in for the E clock
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      phase <= phaseIdle;
      count <= '0;
    end else begin
      case (phase)
        phaseIdle: begin
          // New access only from idle
          if (ciaSpace && transferStart) begin
            phase <= phaseSetup;
            count <= cntWidth'(ciaSetupCycles - 1);
          end
        end
        phaseSetup: begin
          if (count == '0) begin
            phase <= phaseHold;
            count <= cntWidth'(ciaHoldCycles - 1);
          end else begin
            count <= count - 1'b1;
          end
        end
        phaseHold: begin
          if (count == '0) begin
            phase <= phaseIdle;
          end else begin
            count <= count - 1'b1;
          end
        end
        default: begin
          phase <= phaseIdle;
        end
      endcase
    end
  end

  // Enable window is the hold phase
  assign ciaEnable = phase == phaseHold;
  // Ack in the last window cycle
  assign ciaAck    = ciaEnable && (count == '0);

endmodule

// ==== design/autoconfigChain.sv ====
// Autoconfig base address chain
module autoconfigChain (
  input  logic                                   CLK40,
  input  logic                                   RESETn,
  input  logic                                   autoconfigSpace,
  input  logic [7:0]                             offset,
  input  logic [7:0]                             data,
  input  logic                                   writeStrobe,
  output logic [addrMapPkg::bridgeBaseWidth-1:0] bridgeBase,
  output logic [addrMapPkg::ataBaseWidth-1:0]    ataBase,
  output logic [addrMapPkg::proBaseWidth-1:0]    proBase,
  output logic                                   configured
);
  import addrMapPkg::*;

  // Board order in the chain
  localparam logic [1:0] boardBridge = 2'd0;
  localparam logic [1:0] boardAta    = 2'd1;
  localparam logic [1:0] boardPro    = 2'd2;
  localparam logic [1:0] boardDone   = 2'd3;

  logic [1:0] boardPtr;
  logic       acWrite;
  logic       baseWrite;
  logic       z3BaseWrite;
  logic       shutUpWrite;
  logic       advance;

  //////////////////////////////////////////////////
  // Register writes
  //////////////////////////////////////////////////

  // Writes are ignored once the chain is done
  assign acWrite     = autoconfigSpace && writeStrobe && !configured;
  assign baseWrite   = acWrite && (offset == acBaseOffset);
  assign z3BaseWrite = acWrite && (offset == acZ3BaseOffset);
  assign shutUpWrite = acWrite && (offset == acShutUpOffset);

  // Z2 boards finish on the 48 write
  // The Z3 board finishes on the high byte at 44
  always_comb begin
    case (boardPtr)
      boardBridge,
      boardAta: advance = baseWrite || shutUpWrite;
      boardPro: advance = z3BaseWrite || shutUpWrite;
      default:  advance = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Board pointer and bases
  //////////////////////////////////////////////////

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      boardPtr <= boardBridge;
    end else if (advance) begin
      boardPtr <= boardPtr + 2'd1;
    end
  end

  // A shut up board keeps zero
  // Zero is the not configured marker for the decoder
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      bridgeBase <= '0;
      ataBase    <= '0;
      proBase    <= '0;
    end else begin
      case (boardPtr)
        boardBridge: begin
          if (baseWrite) begin
            bridgeBase <= data;
          end
        end
        boardAta: begin
          // 128k board, bit 0 of the byte is below its grain
          if (baseWrite) begin
            ataBase <= data[7 -: ataBaseWidth];
          end
        end
        boardPro: begin
          // Only A31..A28 matter for a 256 MB board
          if (z3BaseWrite) begin
            proBase <= data[7 -: proBaseWidth];
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Pointer past the last board
  assign configured = boardPtr == boardDone;

endmodule

// ==== design/addressDecode.sv ====
// Local bus address decoder
module addressDecode (
  input  logic                                   CLK40,
  input  logic                                   RESETn,
  input  logic [31:12]                           addr,
  input  logic                                   rnW,
  input  busCyclePkg::transferType               tt,
  input  busCyclePkg::transferMod                tm,
  input  logic                                   ovl,
  input  logic                                   ciaEnable,
  input  logic                                   configured,
  input  logic [addrMapPkg::bridgeBaseWidth-1:0] bridgeBase,
  input  logic [addrMapPkg::ataBaseWidth-1:0]    ataBase,
  input  logic [addrMapPkg::proBaseWidth-1:0]    proBase,
  output logic                                   romEnN,
  output logic                                   ramSpaceN,
  output logic                                   regSpaceN,
  output logic                                   ciaSpace,
  output logic                                   ciaCs0N,
  output logic                                   ciaCs1N,
  output logic                                   rtcSpace,
  output logic                                   autoconfigSpace,
  output logic                                   autovector,
  output logic                                   ataSpace,
  output logic                                   ataEnN,
  output logic                                   priCs0,
  output logic                                   priCs1,
  output logic                                   secCs0,
  output logic                                   secCs1,
  output logic                                   bridgeRegEnN,
  output logic                                   proEnN,
  output busCyclePkg::pciAccessType              accessType,
  output logic                                   flashSpace,
  output logic [1:0]                             flashBank
);
  import addrMapPkg::*;
  import busCyclePkg::*;

  logic zorro2Space;
  logic lowRom;
  logic hiRom;
  logic ataCs0;
  logic ataCs1;
  logic ataEnable;
  logic proWindow;
  logic flashHit;

  //////////////////////////////////////////////////
  // Chip set regions
  //////////////////////////////////////////////////

  // Every Zorro II select is qualified here, reset included
  assign zorro2Space = RESETn && (addr[31:24] == zorro2Top);

  // Low ROM only under overlay
  // Kickstart runs from high ROM before it drops ovl
  assign lowRom = (addr[23:19] == romLowRegion) && ovl;
  assign hiRom  = addr[23:19] == romHiRegion;
  assign romEnN = !(zorro2Space && (lowRom || hiRom));

  // Chip RAM takes low memory back once overlay is off
  assign ramSpaceN = !(zorro2Space && !ovl && (addr[23:21] == chipRamRegion));
  assign regSpaceN = !(zorro2Space && (addr[23:16] == regRegion));

  // CIA space goes to the cycle timer
  assign ciaSpace = zorro2Space && (addr[23:16] == ciaRegion);
  // A12 picks the odd CIA, A13 the even one
  assign ciaCs0N  = !(ciaEnable && !addr[12]);
  assign ciaCs1N  = !(ciaEnable && !addr[13]);

  assign rtcSpace        = zorro2Space && (addr[23:17] == rtcRegion);
  assign autoconfigSpace = zorro2Space && (addr[23:16] == autoconfigRegion);

  // Interrupts are all autovectored
  assign autovector = RESETn && (tt == interruptAck) && (addr[31:16] == autovectorTop);

  //////////////////////////////////////////////////
  // ATA port
  //////////////////////////////////////////////////

  // A16 A15 A14 A13 A12   select
  //  0   0   0   0   1    priCs0
  //  0   0   1   0   1    priCs1
  //  0   0   0   1   0    secCs0
  //  0   0   1   1   0    secCs1
  assign ataCs0 = (addr[16:15] == 2'b00) && (addr[13:12] == 2'b01);
  assign ataCs1 = (addr[16:15] == 2'b00) && (addr[13:12] == 2'b10);
  assign priCs0 = !addr[14] && ataCs0;
  assign priCs1 = addr[14] && ataCs0;
  assign secCs0 = !addr[14] && ataCs1;
  assign secCs1 = addr[14] && ataCs1;

  // 128k board, zero base means shut up
  assign ataSpace = zorro2Space && configured && (|ataBase) && (addr[23:17] == ataBase);

  // ROM visible until the first write, ports after that
  assign ataEnN = !(ataSpace && ataEnable);

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      ataEnable <= 1'b0;
    end else if (ataSpace && !rnW) begin
      ataEnable <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // PCI bridge
  //////////////////////////////////////////////////

  // Bridge registers, 64k in Zorro II
  assign bridgeRegEnN = !(zorro2Space && configured && (|bridgeBase)
                          && (addr[23:16] == bridgeBase));

  // Prometheus window, 256 MB in Zorro III
  assign proWindow = RESETn && configured && (|proBase) && (addr[31:28] == proBase);
  assign proEnN    = !proWindow;

  // Window config and io regions first, then alternate space cycles
  always_comb begin
    accessType = memory;
    if (!RESETn) begin
      accessType = config0;
    end else if (proWindow && (addr[27:20] == proConf0Region)) begin
      accessType = config0;
    end else if (proWindow && (addr[27:20] == proConf1Region)) begin
      accessType = config1;
    end else if (proWindow && (addr[27:20] == proIoRegion)) begin
      accessType = io;
    end else if ((tt == alternate) && (tm == conf0Mod)) begin
      accessType = config0;
    end else if ((tt == alternate) && (tm == conf1Mod)) begin
      accessType = config1;
    end
  end

  //////////////////////////////////////////////////
  // Flash
  //////////////////////////////////////////////////

  // Four 512k banks
  always_comb begin
    flashHit = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (addr[23:19] == flashRegions[i]) begin
        flashHit = 1'b1;
      end
    end
  end

  assign flashSpace = zorro2Space && flashHit;
  // Bank number straight from A22 and A20
  assign flashBank  = {addr[22], addr[20]};

endmodule

// ==== design/busCyclePkg.sv ====
// Bus cycle and PCI access codes
package busCyclePkg;

  //////////////////////////////////////////////////
  // 68040 transfer attributes
  //////////////////////////////////////////////////

  // TT1..TT0 of the local bus
  typedef enum logic [1:0] {
    normal       = 2'b00,
    move16       = 2'b01,
    alternate    = 2'b10,
    interruptAck = 2'b11
  } transferType;

  // TM2..TM0, meaning depends on the transfer type
  typedef logic [2:0] transferMod;

  // Alternate space modifiers used for PCI config cycles
  localparam transferMod conf0Mod = 3'b000;
  localparam transferMod conf1Mod = 3'b011;

  //////////////////////////////////////////////////
  // PCI access type
  //////////////////////////////////////////////////

  // Access type   bit1  bit0
  // config 0       0     0
  // config 1       0     1
  // memory         1     0
  // io             1     1
  typedef enum logic [1:0] {
    config0 = 2'b00,
    config1 = 2'b01,
    memory  = 2'b10,
    io      = 2'b11
  } pciAccessType;

endpackage

// ==== design/addrMapPkg.sv ====
// Amiga address map constants
package addrMapPkg;

  //////////////////////////////////////////////////
  // Zorro II fixed regions
  //////////////////////////////////////////////////

  // Bits 31..24 of the 16 MB Zorro II window
  localparam logic [7:0] zorro2Top = 8'h00;

  // Bits 23..16 of the 64k regions
  localparam logic [7:0] ciaRegion        = 8'hBF;
  localparam logic [7:0] regRegion        = 8'hDF;
  localparam logic [7:0] autoconfigRegion = 8'hE8;

  // Bits 23..19, reset vector ROM and high ROM at F8..FF
  localparam logic [4:0] romLowRegion = 5'b00000;
  localparam logic [4:0] romHiRegion  = 5'b11111;

  // Bits 23..21, 2 MB of chip RAM
  localparam logic [2:0] chipRamRegion = 3'b000;

  // Bits 23..17, clock at DC..DD
  localparam logic [6:0] rtcRegion = 7'b1101110;

  // Bits 23..19 of the flash banks A8, B0, E0, F0
  // Index is the bank number
  localparam logic [3:0][4:0] flashRegions = {5'h1E, 5'h1C, 5'h16, 5'h15};

  // Bits 31..16 of the interrupt acknowledge cycle
  localparam logic [15:0] autovectorTop = 16'hFFFF;

  //////////////////////////////////////////////////
  // Prometheus window and autoconfig
  //////////////////////////////////////////////////

  // Bits 27..20 inside the 256 MB window
  localparam logic [7:0] proConf0Region = 8'hFC;
  localparam logic [7:0] proConf1Region = 8'hFD;
  localparam logic [7:0] proIoRegion    = 8'hFE;

  // Base register widths, bridge 64k, ATA 128k, Prometheus 256 MB
  localparam int bridgeBaseWidth = 8;
  localparam int ataBaseWidth    = 7;
  localparam int proBaseWidth    = 4;

  // Autoconfig write registers
  localparam logic [7:0] acZ3BaseOffset = 8'h44;
  localparam logic [7:0] acBaseOffset   = 8'h48;
  localparam logic [7:0] acShutUpOffset = 8'h4C;

endpackage
